//--- source/capture_pkg.sv
// ----------------------------
// Capture datapath definitions
// Lane and word geometry, capture writer states
// ----------------------------
package capture_pkg;

    // Bits per path sample
    localparam int LANE_W = 9;

    // Lanes packed into one bank word
    localparam int LANES_PER_WORD = 4;

    // Bits needed to index a lane in a word
    localparam int LANE_IDX_W = $clog2(LANES_PER_WORD);

    // Bank word width
    localparam int WORD_W = LANE_W * LANES_PER_WORD;

    // Capture writer states
    typedef enum logic [1:0] {
        CAP_IDLE = 2'd0,
        CAP_FILL = 2'd1,
        CAP_FULL = 2'd2
    } cap_state_t;

endpackage

//--- source/wb_regs_pkg.sv
// ----------------------------
// Wishbone register map
// Register addresses, control and status bits, slave states
// ----------------------------
package wb_regs_pkg;

    // Word addresses of the register slave
    typedef enum logic [2:0] {
        REG_CTRL   = 3'd0,
        REG_SEL    = 3'd1,
        REG_ADDR   = 3'd2,
        REG_DATA   = 3'd3,
        REG_STATUS = 3'd4
    } reg_addr_t;

    // REG_CTRL bits
    localparam int CTRL_PATH96_BIT  = 0;
    localparam int CTRL_ARM_BIT     = 1;
    localparam int CTRL_AUTOINC_BIT = 2;

    // REG_STATUS bits
    localparam int STAT_DONE_BIT = 0;
    localparam int STAT_FULL_BIT = 1;

    // Slave states
    typedef enum logic {
        WB_IDLE      = 1'b0,
        WB_READ_WAIT = 1'b1
    } wb_state_t;

endpackage

//--- source/capture_writer.sv
// ----------------------------
// Capture writer
// Packs path samples into bank words and runs the buffer fill
// ----------------------------
`timescale 1ns/1ns
module capture_writer
    import capture_pkg::*;
#(
    parameter int NUM_BANKS = 24,
    parameter int ADDR_W    = 15
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 arm,
    input  logic                 path96_en,
    input  logic                 cap_valid,
    input  logic [LANE_W-1:0]    cap_sample,
    output logic [NUM_BANKS-1:0] wr_en,
    output logic [ADDR_W-1:0]    wr_addr,
    output logic [WORD_W-1:0]    wr_data,
    output logic                 cap_full
);

    localparam int PATHS_FULL = NUM_BANKS * LANES_PER_WORD;
    localparam int PATHS_HALF = PATHS_FULL / 2;
    localparam int PATH_W     = $clog2(PATHS_FULL);

    cap_state_t                          state;
    logic [PATH_W-1:0]                   path_cnt;
    logic [PATH_W-1:0]                   last_path;
    logic [ADDR_W-1:0]                   addr_cnt;
    logic [LANE_IDX_W-1:0]               lane_idx;
    logic [PATH_W-LANE_IDX_W-1:0]        bank_idx;
    logic [(LANES_PER_WORD-1)*LANE_W-1:0] lane_buf;
    logic                                take;

    assign last_path = path96_en ? PATH_W'(PATHS_FULL - 1) : PATH_W'(PATHS_HALF - 1);
    assign lane_idx  = path_cnt[LANE_IDX_W-1:0];
    assign bank_idx  = path_cnt[PATH_W-1:LANE_IDX_W];
    assign take      = (state == CAP_FILL) && cap_valid && !arm;

    // ------------------------------
    // Fill sequencing
    // ------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= CAP_IDLE;
            path_cnt <= '0;
            addr_cnt <= '0;
            wr_en    <= '0;
            cap_full <= 1'b0;
        end else begin
            wr_en    <= '0;
            cap_full <= (state == CAP_FULL);
            if (arm) begin
                // Restart from any state
                state    <= CAP_FILL;
                path_cnt <= '0;
                addr_cnt <= '0;
                cap_full <= 1'b0;
            end else if (take) begin
                if (lane_idx == LANE_IDX_W'(LANES_PER_WORD - 1)) begin
                    for (int b = 0; b < NUM_BANKS; b++) begin
                        wr_en[b] <= (int'(bank_idx) == b);
                    end
                end
                if (path_cnt == last_path) begin
                    path_cnt <= '0;
                    addr_cnt <= addr_cnt + 1'b1;
                    if (&addr_cnt) begin
                        state <= CAP_FULL;
                    end
                end else begin
                    path_cnt <= path_cnt + 1'b1;
                end
            end
        end
    end

    // Lane packing, word goes out with the last lane
    always_ff @(posedge clk) begin
        if (take) begin
            if (lane_idx == LANE_IDX_W'(LANES_PER_WORD - 1)) begin
                wr_data <= {cap_sample, lane_buf};
                wr_addr <= addr_cnt;
            end else begin
                lane_buf[lane_idx*LANE_W +: LANE_W] <= cap_sample;
            end
        end
    end

endmodule

//--- source/capture_bank.sv
// ----------------------------
// Capture bank
// Dual-port memory, synchronous write and read
// ----------------------------
`timescale 1ns/1ns
module capture_bank
    import capture_pkg::*;
#(
    parameter int ADDR_W = 15
) (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [WORD_W-1:0] wr_data,
    input  logic              rd_en,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [WORD_W-1:0] rd_data
);

    logic [WORD_W-1:0] mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Output only moves while the bank is selected
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- source/mdio_read_logic.sv
// ----------------------------
// Buffer read logic
// Bank enable and address, lane select, sweep done flag
// ----------------------------
`timescale 1ns/1ns
module mdio_read_logic
    import capture_pkg::*;
#(
    parameter int NUM_BANKS = 24,
    parameter int ADDR_W    = 15
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        path96_en,
    input  logic [6:0]                  data_sel,
    input  logic [ADDR_W-1:0]           mem_addr,
    input  logic                        read_en,
    input  logic                        done_clr,
    input  logic [NUM_BANKS*WORD_W-1:0] bank_rdata,
    output logic [NUM_BANKS-1:0]        bank_en,
    output logic [ADDR_W-1:0]           bank_addr,
    output logic [LANE_W-1:0]           pkt_data,
    output logic                        pkt_valid,
    output logic                        rd_done
);

    localparam int PATHS_FULL = NUM_BANKS * LANES_PER_WORD;
    localparam int PATHS_HALF = PATHS_FULL / 2;
    localparam int BANK_SEL_W = 7 - LANE_IDX_W;

    logic [BANK_SEL_W-1:0] sel_bank;
    logic [BANK_SEL_W-1:0] bank_q;
    logic [LANE_IDX_W-1:0] lane_q;
    logic [6:0]            last_path;
    logic                  last_q;
    logic                  rd_s1;
    logic                  rd_s2;
    logic [WORD_W-1:0]     word_sel;
    logic [LANE_W-1:0]     lane_data;

    assign sel_bank  = data_sel[6:LANE_IDX_W];
    assign last_path = path96_en ? 7'(PATHS_FULL - 1) : 7'(PATHS_HALF - 1);

    // ------------------------------
    // Request stage
    // ------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bank_en   <= '0;
            bank_addr <= '0;
            bank_q    <= '0;
            lane_q    <= '0;
            last_q    <= 1'b0;
            rd_s1     <= 1'b0;
            rd_s2     <= 1'b0;
        end else begin
            rd_s1 <= read_en;
            rd_s2 <= rd_s1;
            for (int b = 0; b < NUM_BANKS; b++) begin
                bank_en[b] <= read_en && (int'(sel_bank) == b);
            end
            if (read_en) begin
                bank_addr <= mem_addr;
                bank_q    <= sel_bank;
                lane_q    <= data_sel[LANE_IDX_W-1:0];
                // End of sweep is judged here, at read time
                last_q    <= (data_sel == last_path) && (&mem_addr);
            end
        end
    end

    // Word of the held bank, zero when beyond the array
    always_comb begin
        word_sel = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (int'(bank_q) == b) begin
                word_sel = bank_rdata[b*WORD_W +: WORD_W];
            end
        end
    end

    assign lane_data = word_sel[lane_q*LANE_W +: LANE_W];

    // ------------------------------
    // Response stage
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rd_s2) begin
            pkt_data <= lane_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pkt_valid <= 1'b0;
            rd_done   <= 1'b0;
        end else begin
            pkt_valid <= rd_s2;
            if (rd_s2 && last_q) begin
                rd_done <= 1'b1;
            end else if (done_clr) begin
                rd_done <= 1'b0;
            end
        end
    end

endmodule

//--- source/wb_reg_file.sv
// ----------------------------
// Wishbone register slave
// Control, select and address registers, data read sequencing
// ----------------------------
`timescale 1ns/1ns
module wb_reg_file
    import wb_regs_pkg::*;
#(
    parameter int ADDR_W = 15
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [2:0]        wb_adr,
    input  logic [31:0]       wb_wdata,
    input  logic [8:0]        pkt_data,
    input  logic              pkt_valid,
    input  logic              rd_done,
    input  logic              cap_full,
    output logic [31:0]       wb_rdata,
    output logic              wb_ack,
    output logic              path96_en,
    output logic              arm,
    output logic [6:0]        data_sel,
    output logic [ADDR_W-1:0] mem_addr,
    output logic              read_en,
    output logic              done_clr
);

    wb_state_t state;
    reg_addr_t reg_sel;
    logic      ack_q;
    logic      autoinc;
    logic      req;
    logic      data_rd;
    logic      data_done;
    logic [31:0] rdata_q;

    assign reg_sel   = reg_addr_t'(wb_adr);
    // New request, the cycle after an ack is skipped
    assign req       = wb_cyc && wb_stb && !ack_q && (state == WB_IDLE);
    assign data_rd   = req && !wb_we && (reg_sel == REG_DATA);
    assign data_done = (state == WB_READ_WAIT) && pkt_valid;

    assign wb_ack   = ack_q || data_done;
    assign wb_rdata = (state == WB_READ_WAIT) ? {23'b0, pkt_data} : rdata_q;

    // ------------------------------
    // Slave FSM and registers
    // ------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= WB_IDLE;
            ack_q     <= 1'b0;
            read_en   <= 1'b0;
            arm       <= 1'b0;
            done_clr  <= 1'b0;
            path96_en <= 1'b1;
            autoinc   <= 1'b0;
            data_sel  <= '0;
            mem_addr  <= '0;
        end else begin
            ack_q    <= 1'b0;
            read_en  <= 1'b0;
            arm      <= 1'b0;
            done_clr <= 1'b0;
            case (state)
                WB_IDLE: begin
                    if (data_rd) begin
                        read_en <= 1'b1;
                        state   <= WB_READ_WAIT;
                    end else if (req) begin
                        ack_q <= 1'b1;
                        if (wb_we) begin
                            case (reg_sel)
                                REG_CTRL: begin
                                    path96_en <= wb_wdata[CTRL_PATH96_BIT];
                                    arm       <= wb_wdata[CTRL_ARM_BIT];
                                    autoinc   <= wb_wdata[CTRL_AUTOINC_BIT];
                                end
                                REG_SEL:    data_sel <= wb_wdata[6:0];
                                REG_ADDR:   mem_addr <= wb_wdata[ADDR_W-1:0];
                                REG_STATUS: done_clr <= 1'b1;
                                default: ;
                            endcase
                        end
                    end
                end
                WB_READ_WAIT: begin
                    if (pkt_valid) begin
                        state <= WB_IDLE;
                        // Address first, select on wrap
                        if (autoinc) begin
                            mem_addr <= mem_addr + 1'b1;
                            if (&mem_addr) begin
                                data_sel <= data_sel + 1'b1;
                            end
                        end
                    end
                end
                default: state <= WB_IDLE;
            endcase
        end
    end

    // Register read data
    always_ff @(posedge clk) begin
        if (req && !wb_we) begin
            rdata_q <= '0;
            case (reg_sel)
                REG_CTRL: begin
                    rdata_q[CTRL_PATH96_BIT]  <= path96_en;
                    rdata_q[CTRL_AUTOINC_BIT] <= autoinc;
                end
                REG_SEL:  rdata_q[6:0] <= data_sel;
                REG_ADDR: rdata_q[ADDR_W-1:0] <= mem_addr;
                REG_STATUS: begin
                    rdata_q[STAT_DONE_BIT] <= rd_done;
                    rdata_q[STAT_FULL_BIT] <= cap_full;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- source/capture_readout_top.sv
// ----------------------------
// Capture and readout top level
// Writer, bank array, read logic and register slave
// ----------------------------
`timescale 1ns/1ns
module capture_readout_top
    import capture_pkg::*;
#(
    parameter int NUM_BANKS = 24,
    parameter int ADDR_W    = 15
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [2:0]        wb_adr,
    input  logic [31:0]       wb_wdata,
    output logic [31:0]       wb_rdata,
    output logic              wb_ack,
    input  logic              cap_valid,
    input  logic [LANE_W-1:0] cap_sample
);

    // Register file controls
    logic              path96_en;
    logic              arm;
    logic [6:0]        data_sel;
    logic [ADDR_W-1:0] mem_addr;
    logic              read_en;
    logic              done_clr;

    // Capture side
    logic [NUM_BANKS-1:0] wr_en;
    logic [ADDR_W-1:0]    wr_addr;
    logic [WORD_W-1:0]    wr_data;
    logic                 cap_full;

    // Readout side
    logic [NUM_BANKS-1:0]        bank_en;
    logic [ADDR_W-1:0]           bank_addr;
    logic [NUM_BANKS*WORD_W-1:0] bank_rdata;
    logic [LANE_W-1:0]           pkt_data;
    logic                        pkt_valid;
    logic                        rd_done;

    capture_writer #(
        .NUM_BANKS (NUM_BANKS),
        .ADDR_W    (ADDR_W)
    ) i_writer (
        .clk        (clk),
        .rstn       (rstn),
        .arm        (arm),
        .path96_en  (path96_en),
        .cap_valid  (cap_valid),
        .cap_sample (cap_sample),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .cap_full   (cap_full)
    );

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        capture_bank #(
            .ADDR_W (ADDR_W)
        ) i_bank (
            .clk     (clk),
            .wr_en   (wr_en[g]),
            .wr_addr (wr_addr),
            .wr_data (wr_data),
            .rd_en   (bank_en[g]),
            .rd_addr (bank_addr),
            .rd_data (bank_rdata[g*WORD_W +: WORD_W])
        );
    end

    mdio_read_logic #(
        .NUM_BANKS (NUM_BANKS),
        .ADDR_W    (ADDR_W)
    ) i_read (
        .clk        (clk),
        .rstn       (rstn),
        .path96_en  (path96_en),
        .data_sel   (data_sel),
        .mem_addr   (mem_addr),
        .read_en    (read_en),
        .done_clr   (done_clr),
        .bank_rdata (bank_rdata),
        .bank_en    (bank_en),
        .bank_addr  (bank_addr),
        .pkt_data   (pkt_data),
        .pkt_valid  (pkt_valid),
        .rd_done    (rd_done)
    );

    wb_reg_file #(
        .ADDR_W (ADDR_W)
    ) i_regs (
        .clk       (clk),
        .rstn      (rstn),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_wdata  (wb_wdata),
        .pkt_data  (pkt_data),
        .pkt_valid (pkt_valid),
        .rd_done   (rd_done),
        .cap_full  (cap_full),
        .wb_rdata  (wb_rdata),
        .wb_ack    (wb_ack),
        .path96_en (path96_en),
        .arm       (arm),
        .data_sel  (data_sel),
        .mem_addr  (mem_addr),
        .read_en   (read_en),
        .done_clr  (done_clr)
    );

endmodule

//--- tests/tb_capture_readout.sv
// ----------------------------
// Testbench for the capture and readout top level
// Wishbone master tasks, sample driver, sample model, read table
// ----------------------------
`timescale 1ns/1ns
module tb_capture_readout
    import wb_regs_pkg::*;
();

    localparam int NUM_BANKS   = 6;
    localparam int ADDR_W      = 3;
    localparam int DEPTH       = 2**ADDR_W;
    localparam int PATHS_FULL  = NUM_BANKS * 4;
    localparam int PATHS_HALF  = NUM_BANKS * 2;
    localparam int ACK_TIMEOUT = 20;
    localparam int TBL_N       = 12;

    logic        clk;
    logic        rstn;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [31:0] wb_wdata;
    logic [31:0] wb_rdata;
    logic        wb_ack;
    logic        cap_valid;
    logic [8:0]  cap_sample;

    integer      seed;
    logic [8:0]  model [PATHS_FULL*DEPTH];
    logic [31:0] rd;

    // Read table of full mode flag, path, address and auto-increment per entry
    int tbl_mode [TBL_N] = '{1, 1, 1, 1, 1, 1, 1, 1, 0, 0, 0, 0};
    int tbl_sel  [TBL_N] = '{0, 1, 3, 4, 10, 15, 23, 17, 0, 5, 11, 7};
    int tbl_addr [TBL_N] = '{0, 0, 5, 2, 7, 3, 6, 1, 0, 4, 6, 7};
    int tbl_inc  [TBL_N] = '{0, 0, 0, 1, 1, 0, 0, 1, 0, 1, 0, 1};

    capture_readout_top #(
        .NUM_BANKS (NUM_BANKS),
        .ADDR_W    (ADDR_W)
    ) i_dut (
        .clk        (clk),
        .rstn       (rstn),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_wdata   (wb_wdata),
        .wb_rdata   (wb_rdata),
        .wb_ack     (wb_ack),
        .cap_valid  (cap_valid),
        .cap_sample (cap_sample)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else
            fail_stop($sformatf("CHECK FAILED: %s expected 0x%0h actual 0x%0h",
                                name, expected, actual));
    endtask

    // One classic cycle that starts and ends 1 ns after a rising edge
    task automatic bus_cycle(input logic we, input logic [2:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int cycles;
        cycles   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_wdata = wdata;
        rdata    = '0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!wb_ack && cycles < ACK_TIMEOUT);
        if (!wb_ack) begin
            fail_stop($sformatf("No Wishbone ack for address %0d within %0d cycles",
                                adr, ACK_TIMEOUT));
        end else begin
            rdata  = wb_rdata;
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we  = 1'b0;
        end
    endtask

    task automatic bus_write(input logic [2:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic bus_read(input logic [2:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'h0, data);
    endtask

    // Samples with random gaps in cap_valid and accepted ones kept in the model
    task automatic stream_samples(input int count, input bit store);
        int         taken;
        int         cycles;
        logic [8:0] s;
        taken  = 0;
        cycles = 0;
        while (taken < count && cycles < count * 8) begin
            @(posedge clk);
            #1;
            cycles++;
            cap_valid  = ($random(seed) & 3) != 0;
            s          = 9'($random(seed));
            cap_sample = s;
            if (cap_valid) begin
                if (store) begin
                    model[taken] = s;
                end
                taken++;
            end
        end
        if (taken < count) begin
            fail_stop("Sample stream did not finish in time");
        end else begin
            @(posedge clk);
            #1;
            cap_valid = 1'b0;
        end
    endtask

    task automatic wait_full();
        int          polls;
        logic [31:0] st;
        polls = 0;
        st    = '0;
        while (!st[STAT_FULL_BIT] && polls < 10) begin
            bus_read(REG_STATUS, st);
            polls++;
        end
        if (!st[STAT_FULL_BIT]) begin
            fail_stop("Capture full flag never came up");
        end
    endtask

    task automatic run_table(input int mode, input int paths);
        logic [31:0] data;
        for (int i = 0; i < TBL_N; i++) begin
            if (tbl_mode[i] == mode) begin
                bus_write(REG_CTRL, (32'(mode) << CTRL_PATH96_BIT) |
                                    (32'(tbl_inc[i]) << CTRL_AUTOINC_BIT));
                bus_write(REG_SEL, 32'(tbl_sel[i]));
                bus_write(REG_ADDR, 32'(tbl_addr[i]));
                bus_read(REG_DATA, data);
                check_value($sformatf("table %0d data", i),
                            32'(model[tbl_addr[i] * paths + tbl_sel[i]]), data);
                if (tbl_inc[i] != 0) begin
                    // Address steps and select steps on wrap
                    bus_read(REG_ADDR, data);
                    check_value($sformatf("table %0d next addr", i),
                                32'((tbl_addr[i] + 1) % DEPTH), data);
                    bus_read(REG_SEL, data);
                    check_value($sformatf("table %0d next sel", i),
                                32'(tbl_sel[i] + ((tbl_addr[i] == DEPTH - 1) ? 1 : 0)), data);
                end
            end
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        seed       = 33;
        rstn       = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_wdata   = '0;
        cap_valid  = 1'b0;
        cap_sample = '0;

        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            #1;
            check_value("ack in reset", 32'h0, 32'(wb_ack));
        end
        rstn = 1'b1;
        repeat (2) begin
            @(posedge clk);
            #1;
            check_value("ack before strobe", 32'h0, 32'(wb_ack));
        end
        bus_read(REG_STATUS, rd);
        check_value("status after reset", 32'h0, rd);
        bus_read(REG_CTRL, rd);
        check_value("ctrl after reset", 32'h1, rd);

        // Full mode capture and dropped extras
        bus_write(REG_CTRL, (32'h1 << CTRL_PATH96_BIT) | (32'h1 << CTRL_ARM_BIT));
        stream_samples(PATHS_FULL * DEPTH, 1'b1);
        wait_full();
        stream_samples(10, 1'b0);
        run_table(1, PATHS_FULL);

        // Auto-increment sweep over the last two paths
        bus_write(REG_CTRL, (32'h1 << CTRL_PATH96_BIT) | (32'h1 << CTRL_AUTOINC_BIT));
        bus_write(REG_STATUS, 32'h0);
        bus_write(REG_SEL, 32'd22);
        bus_write(REG_ADDR, 32'd0);
        for (int i = 0; i < 2 * DEPTH; i++) begin
            if (i == 2 * DEPTH - 1) begin
                bus_read(REG_STATUS, rd);
                check_value("done before last read", 32'h2, rd);
            end
            bus_read(REG_DATA, rd);
            check_value($sformatf("sweep read %0d", i),
                        32'(model[(i % DEPTH) * PATHS_FULL + 22 + i / DEPTH]), rd);
        end
        bus_read(REG_STATUS, rd);
        check_value("done after sweep", 32'h3, rd);
        bus_write(REG_STATUS, 32'h0);
        bus_read(REG_STATUS, rd);
        check_value("done cleared", 32'h2, rd);

        // Half mode capture
        bus_write(REG_CTRL, 32'h1 << CTRL_ARM_BIT);
        bus_read(REG_STATUS, rd);
        check_value("full cleared by arm", 32'h0, rd);
        stream_samples(PATHS_HALF * DEPTH, 1'b1);
        wait_full();
        run_table(0, PATHS_HALF);
        bus_write(REG_CTRL, 32'h0);
        bus_write(REG_SEL, 32'(PATHS_HALF - 1));
        bus_write(REG_ADDR, 32'(DEPTH - 1));
        bus_read(REG_DATA, rd);
        check_value("half last path data",
                    32'(model[(DEPTH - 1) * PATHS_HALF + PATHS_HALF - 1]), rd);
        bus_read(REG_STATUS, rd);
        check_value("half mode done set", 32'h3, rd);
        bus_write(REG_STATUS, 32'h0);
        bus_write(REG_SEL, 32'(PATHS_FULL - 1));
        bus_read(REG_DATA, rd);
        // Upper banks still hold the full mode capture
        check_value("half mode upper path data",
                    32'(model[(DEPTH - 1) * PATHS_FULL + PATHS_FULL - 1]), rd);
        bus_read(REG_STATUS, rd);
        check_value("half mode done clear", 32'h2, rd);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- vlog.f
source/capture_pkg.sv
source/wb_regs_pkg.sv
source/capture_writer.sv
source/capture_bank.sv
source/mdio_read_logic.sv
source/wb_reg_file.sv
source/capture_readout_top.sv
tests/tb_capture_readout.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the capture readout testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_capture_readout \
    -f vlog.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

./obj_dir/Vtb_capture_readout
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit 1
fi

echo "Simulation finished"
exit 0
